// File: verilog.f
common/dcache_cfg_pkg.sv
common/dcache_bus_pkg.sv
logic/line_store.sv
logic/line_state.sv
logic/word_merge.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
test/l2_model.sv
test/dcache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS = --lint-only --timing --timescale 1ns/1ps
TOP       = dcache_tb
FILELIST  = verilog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the simulation passes only if the log holds the pass line
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: test/dcache_tb.sv
module dcache_tb
    import dcache_cfg_pkg::*, dcache_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          timeout_cycles = 200;
    localparam logic [31:0] seed           = 32'hbf6de3d5;

    typedef struct {
        cache_op_t op;
        addr_t     addr;
        word_t     data;
        strb_t     strb;
        int        exp_rd;
        int        exp_wr;
        string     name;
    } op_entry_t;

    logic       CLK = 1'b0;
    logic       RST;
    logic       req_valid;
    logic       req_ready;
    cpu_req_t   req;
    logic       rsp_valid;
    cpu_rsp_t   rsp;
    logic       l2_rd_valid;
    logic       l2_rd_ready;
    l2_rd_req_t l2_rd;
    logic       l2_fill_valid;
    line_t      l2_fill_data;
    logic       l2_wr_valid;
    logic       l2_wr_ready;
    l2_wr_req_t l2_wr;

    int        check_errors = 0;
    int        timeouts     = 0;
    int        rd_count     = 0;
    int        wr_count     = 0;
    word_t     ref_mem [addr_t];
    op_entry_t ops [$];

    always #10 CLK = ~CLK;

    dcache_top dut0 (
        .CLK           (CLK),
        .RST           (RST),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .l2_rd_valid   (l2_rd_valid),
        .l2_rd_ready   (l2_rd_ready),
        .l2_rd         (l2_rd),
        .l2_fill_valid (l2_fill_valid),
        .l2_fill_data  (l2_fill_data),
        .l2_wr_valid   (l2_wr_valid),
        .l2_wr_ready   (l2_wr_ready),
        .l2_wr         (l2_wr)
    );

    l2_model l2_0 (
        .CLK        (CLK),
        .RST        (RST),
        .rd_valid   (l2_rd_valid),
        .rd_ready   (l2_rd_ready),
        .rd         (l2_rd),
        .fill_valid (l2_fill_valid),
        .fill_data  (l2_fill_data),
        .wr_valid   (l2_wr_valid),
        .wr_ready   (l2_wr_ready),
        .wr         (l2_wr)
    );

    // handshakes counted just before the edge that completes them
    always @(negedge CLK) begin
        if (l2_rd_valid && l2_rd_ready) begin
            rd_count++;
        end
        if (l2_wr_valid && l2_wr_ready) begin
            wr_count++;
        end
    end

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic addr_t word_key(addr_t a);
        addr_t wa;
        wa = a;
        wa[byte_bits-1:0] = '0;
        return wa;
    endfunction

    function automatic word_t pattern_word(addr_t wa);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next(seed ^ (wa >> byte_bits));
        lo = lcg_next(hi);
        return {hi, lo};
    endfunction

    // memory as the processor should see it
    function automatic word_t ref_word(addr_t a);
        if (ref_mem.exists(word_key(a))) begin
            return ref_mem[word_key(a)];
        end
        return pattern_word(word_key(a));
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t data, strb_t strb);
        word_t w;
        w = old;
        for (int b = 0; b < word_bits / 8; b++) begin
            if (strb[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return w;
    endfunction

    task automatic add_op(input cache_op_t op, input addr_t addr, input word_t data,
                          input strb_t strb, input int exp_rd, input int exp_wr,
                          input string name);
        op_entry_t e;
        e.op     = op;
        e.addr   = addr;
        e.data   = data;
        e.strb   = strb;
        e.exp_rd = exp_rd;
        e.exp_wr = exp_wr;
        e.name   = name;
        ops.push_back(e);
    endtask

    task automatic check_l2_memory(input string name);
        foreach (ref_mem[a]) begin
            assert (l2_0.peek_word(a) == ref_mem[a]) else begin
                check_errors++;
                $display("Mismatch %s l2 word %h: expected %h, actual %h",
                         name, a, ref_mem[a], l2_0.peek_word(a));
            end
        end
    endtask

    task automatic run_op(input op_entry_t e, output bit ok);
        word_t exp;
        int    waited;
        int    lat;
        int    rd0;
        int    wr0;
        ok = 1'b0;
        exp = '0;
        if (e.op == op_write) begin
            exp = merge_bytes(ref_word(e.addr), e.data, e.strb);
            ref_mem[word_key(e.addr)] = exp;
        end else if (e.op == op_read) begin
            exp = ref_word(e.addr);
        end
        rd0 = rd_count;
        wr0 = wr_count;
        @(posedge CLK);
        #1;
        req_valid = 1'b1;
        req       = '{op: e.op, addr: e.addr, wdata: e.data, wstrb: e.strb};
        waited    = 0;
        do begin
            @(negedge CLK);
            waited++;
        end while (!req_ready && waited < timeout_cycles);
        if (!req_ready) begin
            timeouts++;
            $display("%s: timed out waiting for the cache to accept the request", e.name);
            return;
        end
        @(posedge CLK);
        #1;
        req_valid = 1'b0;
        lat = -1;
        do begin
            @(negedge CLK);
            lat++;
        end while (!rsp_valid && lat < timeout_cycles);
        if (!rsp_valid) begin
            timeouts++;
            $display("%s: timed out waiting for the response", e.name);
            return;
        end
        ok = 1'b1;
        assert (rsp.rdata == exp) else begin
            check_errors++;
            $display("Mismatch %s rdata: expected %h, actual %h", e.name, exp, rsp.rdata);
        end
        assert (rd_count - rd0 == e.exp_rd) else begin
            check_errors++;
            $display("Mismatch %s l2 reads: expected %0d, actual %0d",
                     e.name, e.exp_rd, rd_count - rd0);
        end
        assert (wr_count - wr0 == e.exp_wr) else begin
            check_errors++;
            $display("Mismatch %s l2 writes: expected %0d, actual %0d",
                     e.name, e.exp_wr, wr_count - wr0);
        end
        // hits answer two cycles after acceptance
        if (e.op != op_flush && e.exp_rd == 0) begin
            assert (lat == 2) else begin
                check_errors++;
                $display("Mismatch %s latency: expected 2, actual %0d", e.name, lat);
            end
        end
        if (e.op == op_flush) begin
            check_l2_memory(e.name);
        end
    endtask

    initial begin
        bit ok;
        RST       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        // index 0 holds tags 2 and 3, index 35 takes the store miss
        add_op(op_read,  32'h0000_1000, '0, '0, 1, 0, "reset_read");
        add_op(op_read,  32'h0000_1008, '0, '0, 0, 0, "hit_read");
        add_op(op_write, 32'h0000_1010, 64'h1122_3344_5566_7788, 8'b0011_1100, 0, 0, "store_hit");
        add_op(op_read,  32'h0000_1010, '0, '0, 0, 0, "store_readback");
        add_op(op_read,  32'h0000_1810, '0, '0, 1, 1, "evict_read");
        add_op(op_read,  32'h0000_1010, '0, '0, 1, 0, "evicted_read");
        add_op(op_write, 32'h0000_2468, 64'hdead_beef_0bad_f00d, 8'hf0, 1, 0, "store_miss");
        add_op(op_read,  32'h0000_2468, '0, '0, 0, 0, "alloc_readback");
        add_op(op_write, 32'h0000_1018, 64'ha5a5_5a5a_c3c3_3c3c, 8'h81, 0, 0, "store_again");
        add_op(op_flush, 32'h0000_0000, '0, '0, 0, 2, "flush");
        add_op(op_read,  32'h0000_2460, '0, '0, 1, 0, "post_flush_read");
        add_op(op_read,  32'h0000_1018, '0, '0, 1, 0, "post_flush_store");
        repeat (4) @(posedge CLK);
        #1;
        RST = 1'b0;
        @(negedge CLK);
        assert (req_ready && !rsp_valid && !l2_rd_valid && !l2_wr_valid) else begin
            check_errors++;
            $display("after reset the cache is not idle: ready=%b rsp=%b l2_rd=%b l2_wr=%b",
                     req_ready, rsp_valid, l2_rd_valid, l2_wr_valid);
        end
        ok = 1'b1;
        foreach (ops[i]) begin
            if (ok) begin
                run_op(ops[i], ok);
            end
        end
        $display("check errors: %0d, timeouts: %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: test/l2_model.sv
module l2_model
    import dcache_cfg_pkg::*, dcache_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RST,
    input  logic       rd_valid,
    output logic       rd_ready,
    input  l2_rd_req_t rd,
    output logic       fill_valid,
    output line_t      fill_data,
    input  logic       wr_valid,
    output logic       wr_ready,
    input  l2_wr_req_t wr
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] seed = 32'hbf6de3d5;

    // only lines that were written back are stored
    line_t       mem [line_addr_t];
    logic [31:0] rng = seed;
    int          rd_wait;
    int          wr_wait;
    int          fill_wait;
    logic        fill_pending;
    line_addr_t  fill_addr;
    logic        rst_s;
    logic        rd_hs;
    logic        wr_hs;
    logic        rd_seen;
    logic        wr_seen;
    l2_rd_req_t  rd_s;
    l2_wr_req_t  wr_s;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t pattern_word(addr_t wa);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next(seed ^ (wa >> byte_bits));
        lo = lcg_next(hi);
        return {hi, lo};
    endfunction

    function automatic line_t line_at(line_addr_t la);
        line_t l;
        if (mem.exists(la)) begin
            return mem[la];
        end
        for (int w = 0; w < words_per_line; w++) begin
            l[w*word_bits +: word_bits] = pattern_word({la, offset_bits'(w * word_bits / 8)});
        end
        return l;
    endfunction

    function automatic word_t peek_word(addr_t a);
        line_t l;
        l = line_at(a[addr_bits-1:offset_bits]);
        return l[a[offset_bits-1:byte_bits]*word_bits +: word_bits];
    endfunction

    // back-pressure of 0 to 3 cycles
    function automatic int draw_delay();
        rng = lcg_next(rng);
        return int'(rng[31:30]);
    endfunction

    initial begin
        rd_ready     = 1'b0;
        wr_ready     = 1'b0;
        fill_valid   = 1'b0;
        fill_data    = '0;
        fill_pending = 1'b0;
        fill_wait    = 0;
        rd_wait      = draw_delay();
        wr_wait      = draw_delay();
        forever begin
            // sample mid-cycle, what the next edge will see
            @(negedge CLK);
            rst_s   = RST;
            rd_hs   = rd_valid && rd_ready;
            wr_hs   = wr_valid && wr_ready;
            rd_seen = rd_valid;
            wr_seen = wr_valid;
            rd_s    = rd;
            wr_s    = wr;
            @(posedge CLK);
            #1;
            fill_valid = 1'b0;
            if (rst_s) begin
                rd_ready     = 1'b0;
                wr_ready     = 1'b0;
                fill_pending = 1'b0;
            end else begin
                if (wr_hs) begin
                    mem[wr_s.line_addr] = wr_s.data;
                    wr_ready = 1'b0;
                    wr_wait  = draw_delay();
                end else if (wr_seen && !wr_ready) begin
                    if (wr_wait == 0) begin
                        wr_ready = 1'b1;
                    end else begin
                        wr_wait--;
                    end
                end
                if (rd_hs) begin
                    fill_pending = 1'b1;
                    fill_addr    = rd_s.line_addr;
                    fill_wait    = draw_delay();
                    rd_ready     = 1'b0;
                    rd_wait      = draw_delay();
                end else if (rd_seen && !rd_ready) begin
                    if (rd_wait == 0) begin
                        rd_ready = 1'b1;
                    end else begin
                        rd_wait--;
                    end
                end
                if (fill_pending) begin
                    if (fill_wait == 0) begin
                        fill_valid   = 1'b1;
                        fill_data    = line_at(fill_addr);
                        fill_pending = 1'b0;
                    end else begin
                        fill_wait--;
                    end
                end
            end
        end
    end

endmodule

// File: dcache/dcache_top.sv
module dcache_top
    import dcache_cfg_pkg::*, dcache_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RST,
    input  logic       req_valid,
    output logic       req_ready,
    input  cpu_req_t   req,
    output logic       rsp_valid,
    output cpu_rsp_t   rsp,
    output logic       l2_rd_valid,
    input  logic       l2_rd_ready,
    output l2_rd_req_t l2_rd,
    input  logic       l2_fill_valid,
    input  line_t      l2_fill_data,
    output logic       l2_wr_valid,
    input  logic       l2_wr_ready,
    output l2_wr_req_t l2_wr
);

    index_t   idx;
    logic     tag_we;
    tag_t     tag_wdata;
    tag_t     tag_rdata;
    logic     data_we;
    line_t    data_wdata;
    line_t    data_rdata;
    logic     valid;
    logic     dirty;
    logic     state_we;
    logic     set_valid;
    logic     set_dirty;
    cpu_req_t cur_req;
    line_t    merge_line;
    word_t    rd_word;
    line_t    merged_line;

    dcache_ctrl ctrl0 (
        .CLK           (CLK),
        .RST           (RST),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .l2_rd_valid   (l2_rd_valid),
        .l2_rd_ready   (l2_rd_ready),
        .l2_rd         (l2_rd),
        .l2_fill_valid (l2_fill_valid),
        .l2_fill_data  (l2_fill_data),
        .l2_wr_valid   (l2_wr_valid),
        .l2_wr_ready   (l2_wr_ready),
        .l2_wr         (l2_wr),
        .idx           (idx),
        .tag_we        (tag_we),
        .tag_wdata     (tag_wdata),
        .tag_rdata     (tag_rdata),
        .data_we       (data_we),
        .data_wdata    (data_wdata),
        .data_rdata    (data_rdata),
        .valid         (valid),
        .dirty         (dirty),
        .state_we      (state_we),
        .set_valid     (set_valid),
        .set_dirty     (set_dirty),
        .cur_req       (cur_req),
        .merge_line    (merge_line),
        .rd_word       (rd_word),
        .merged_line   (merged_line)
    );

    line_store #(.payload_t(tag_t)) tag_store (
        .CLK   (CLK),
        .we    (tag_we),
        .idx   (idx),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    line_store #(.payload_t(line_t)) data_store (
        .CLK   (CLK),
        .we    (data_we),
        .idx   (idx),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

    line_state state0 (
        .CLK       (CLK),
        .RST       (RST),
        .idx       (idx),
        .we        (state_we),
        .set_valid (set_valid),
        .set_dirty (set_dirty),
        .valid     (valid),
        .dirty     (dirty)
    );

    word_merge merge0 (
        .req         (cur_req),
        .line_in     (merge_line),
        .rd_word     (rd_word),
        .merged_line (merged_line)
    );

endmodule

// File: dcache/dcache_ctrl.sv
module dcache_ctrl
    import dcache_cfg_pkg::*, dcache_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RST,
    input  logic       req_valid,
    output logic       req_ready,
    input  cpu_req_t   req,
    output logic       rsp_valid,
    output cpu_rsp_t   rsp,
    output logic       l2_rd_valid,
    input  logic       l2_rd_ready,
    output l2_rd_req_t l2_rd,
    input  logic       l2_fill_valid,
    input  line_t      l2_fill_data,
    output logic       l2_wr_valid,
    input  logic       l2_wr_ready,
    output l2_wr_req_t l2_wr,
    output index_t     idx,
    output logic       tag_we,
    output tag_t       tag_wdata,
    input  tag_t       tag_rdata,
    output logic       data_we,
    output line_t      data_wdata,
    input  line_t      data_rdata,
    input  logic       valid,
    input  logic       dirty,
    output logic       state_we,
    output logic       set_valid,
    output logic       set_dirty,
    output cpu_req_t   cur_req,
    output line_t      merge_line,
    input  word_t      rd_word,
    input  line_t      merged_line
);

    typedef enum logic [3:0] {
        S_IDLE, S_READ, S_LOOKUP, S_WB, S_RD, S_FILL,
        S_FL_SCAN, S_FL_LOAD, S_FL_WB
    } state_t;

    state_t     state;
    index_t     flush_idx;
    logic       accept;
    logic       in_flush;
    logic       hit;
    logic       miss;
    logic       wb_load;
    logic       rd_start;
    logic       flush_step;
    logic       flush_last;
    logic       rsp_set;
    tag_t       cur_tag;
    index_t     cur_index;
    line_addr_t cur_line_addr;

    assign cur_tag       = cur_req.addr[addr_bits-1 -: tag_bits];
    assign cur_index     = cur_req.addr[offset_bits +: index_bits];
    assign cur_line_addr = cur_req.addr[addr_bits-1:offset_bits];

    assign req_ready = (state == S_IDLE);
    assign accept    = req_valid && req_ready;
    assign in_flush  = (state == S_FL_SCAN) || (state == S_FL_LOAD) || (state == S_FL_WB);
    assign idx       = in_flush ? flush_idx : cur_index;

    // tag and valid are compared one cycle after the store read
    assign hit  = (state == S_LOOKUP) && valid && (tag_rdata == cur_tag);
    assign miss = (state == S_LOOKUP) && !hit;

    assign wb_load  = (miss && dirty) || (state == S_FL_LOAD);
    assign rd_start = (miss && !dirty) || (state == S_WB && l2_wr_ready);

    assign flush_last = (flush_idx == index_t'(num_lines - 1));
    assign flush_step = (state == S_FL_SCAN && !(valid && dirty))
                     || (state == S_FL_WB && l2_wr_ready);

    assign rsp_set = hit || (state == S_FILL && l2_fill_valid) || (flush_step && flush_last);

    // refill line goes through the merge so a pending store lands on it
    assign merge_line = (state == S_FILL) ? l2_fill_data : data_rdata;
    assign data_wdata = merged_line;
    assign tag_wdata  = cur_tag;

    always_comb begin
        tag_we    = 1'b0;
        data_we   = 1'b0;
        state_we  = 1'b0;
        set_valid = 1'b0;
        set_dirty = 1'b0;
        if (hit && cur_req.op == op_write) begin
            data_we   = 1'b1;
            state_we  = 1'b1;
            set_valid = 1'b1;
            set_dirty = 1'b1;
        end else if (state == S_FILL && l2_fill_valid) begin
            tag_we    = 1'b1;
            data_we   = 1'b1;
            state_we  = 1'b1;
            set_valid = 1'b1;
            set_dirty = (cur_req.op == op_write);
        end else if (flush_step) begin
            // both bits cleared
            state_we  = 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state       <= S_IDLE;
            flush_idx   <= '0;
            rsp_valid   <= 1'b0;
            l2_rd_valid <= 1'b0;
            l2_wr_valid <= 1'b0;
        end else begin
            rsp_valid <= rsp_set;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        flush_idx <= '0;
                        state     <= (req.op == op_flush) ? S_FL_SCAN : S_READ;
                    end
                end
                S_READ: state <= S_LOOKUP;
                S_LOOKUP: begin
                    if (hit) begin
                        state <= S_IDLE;
                    end else if (dirty) begin
                        l2_wr_valid <= 1'b1;
                        state       <= S_WB;
                    end else begin
                        l2_rd_valid <= 1'b1;
                        state       <= S_RD;
                    end
                end
                S_WB: begin
                    if (l2_wr_ready) begin
                        l2_wr_valid <= 1'b0;
                        l2_rd_valid <= 1'b1;
                        state       <= S_RD;
                    end
                end
                S_RD: begin
                    if (l2_rd_ready) begin
                        l2_rd_valid <= 1'b0;
                        state       <= S_FILL;
                    end
                end
                S_FILL: begin
                    if (l2_fill_valid) begin
                        state <= S_IDLE;
                    end
                end
                S_FL_SCAN: begin
                    // clean lines take one cycle each
                    if (valid && dirty) begin
                        state <= S_FL_LOAD;
                    end else if (flush_last) begin
                        state <= S_IDLE;
                    end else begin
                        flush_idx <= flush_idx + 1'b1;
                    end
                end
                S_FL_LOAD: begin
                    l2_wr_valid <= 1'b1;
                    state       <= S_FL_WB;
                end
                S_FL_WB: begin
                    if (l2_wr_ready) begin
                        l2_wr_valid <= 1'b0;
                        if (flush_last) begin
                            state <= S_IDLE;
                        end else begin
                            flush_idx <= flush_idx + 1'b1;
                            state     <= S_FL_SCAN;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            cur_req <= req;
        end
        if (rsp_set) begin
            rsp <= '{rdata: (cur_req.op == op_flush) ? word_t'(0) : rd_word};
        end
        // victim data is the registered store output at idx
        if (wb_load) begin
            l2_wr <= '{line_addr: {tag_rdata, idx}, data: data_rdata};
        end
        if (rd_start) begin
            l2_rd <= '{line_addr: cur_line_addr};
        end
    end

    a_rd_hold: assert property (@(posedge CLK) disable iff (RST)
        l2_rd_valid && !l2_rd_ready |=> l2_rd_valid && $stable(l2_rd));

    a_wr_hold: assert property (@(posedge CLK) disable iff (RST)
        l2_wr_valid && !l2_wr_ready |=> l2_wr_valid && $stable(l2_wr));

    a_rsp_pulse: assert property (@(posedge CLK) disable iff (RST)
        rsp_valid |=> !rsp_valid);

endmodule

// File: logic/word_merge.sv
module word_merge
    import dcache_cfg_pkg::*, dcache_bus_pkg::*;
(
    input  cpu_req_t req,
    input  line_t    line_in,
    output word_t    rd_word,
    output line_t    merged_line
);

    logic [offset_bits-byte_bits-1:0] word_sel;
    word_t                            old_word;
    word_t                            new_word;

    assign word_sel = req.addr[offset_bits-1:byte_bits];
    assign old_word = line_in[word_sel*word_bits +: word_bits];

    // byte strobes only matter for stores
    always_comb begin
        new_word = old_word;
        if (req.op == op_write) begin
            for (int b = 0; b < word_bits / 8; b++) begin
                if (req.wstrb[b]) begin
                    new_word[b*8 +: 8] = req.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        merged_line = line_in;
        merged_line[word_sel*word_bits +: word_bits] = new_word;
    end

    assign rd_word = new_word;

endmodule

// File: logic/line_state.sv
module line_state
    import dcache_cfg_pkg::*;
(
    input  logic   CLK,
    input  logic   RST,
    input  index_t idx,
    input  logic   we,
    input  logic   set_valid,
    input  logic   set_dirty,
    output logic   valid,
    output logic   dirty
);

    logic [num_lines-1:0] valid_bits;
    logic [num_lines-1:0] dirty_bits;

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (we) begin
            valid_bits[idx] <= set_valid;
            dirty_bits[idx] <= set_dirty;
        end
    end

    // combinational lookup
    assign valid = valid_bits[idx];
    assign dirty = dirty_bits[idx];

    // controller must never leave a dirty line without its valid bit
    a_dirty_valid: assert property (@(posedge CLK) disable iff (RST)
        (dirty_bits & ~valid_bits) == '0);

endmodule

// File: logic/line_store.sv
module line_store
    import dcache_cfg_pkg::*;
#(
    parameter type payload_t = line_t
) (
    input  logic     CLK,
    input  logic     we,
    input  index_t   idx,
    input  payload_t wdata,
    output payload_t rdata
);

    payload_t mem [num_lines];

    // registered read, old contents on a write edge
    always_ff @(posedge CLK) begin
        if (we) begin
            mem[idx] <= wdata;
        end
        rdata <= mem[idx];
    end

endmodule

// File: common/dcache_bus_pkg.sv
package dcache_bus_pkg;

    import dcache_cfg_pkg::*;

    // processor operation codes
    typedef enum logic [1:0] {
        op_read  = 2'b01,
        op_write = 2'b10,
        op_flush = 2'b11
    } cache_op_t;

    // load/store port request
    typedef struct packed {
        cache_op_t op;
        addr_t     addr;
        word_t     wdata;
        strb_t     wstrb;
    } cpu_req_t;

    // one word back per accepted request
    typedef struct packed {
        word_t rdata;
    } cpu_rsp_t;

    // refill request, line arrives later on the fill port
    typedef struct packed {
        line_addr_t line_addr;
    } l2_rd_req_t;

    // victim or flush write-back, done at the handshake
    typedef struct packed {
        line_addr_t line_addr;
        line_t      data;
    } l2_wr_req_t;

endpackage

// File: common/dcache_cfg_pkg.sv
package dcache_cfg_pkg;

    // cache geometry
    localparam int addr_bits      = 32;
    localparam int word_bits      = 64;
    localparam int words_per_line = 4;
    localparam int num_lines      = 64;

    // derived address split
    localparam int byte_bits   = $clog2(word_bits / 8);
    localparam int offset_bits = $clog2(words_per_line * word_bits / 8);
    localparam int index_bits  = $clog2(num_lines);
    localparam int tag_bits    = addr_bits - index_bits - offset_bits;
    localparam int line_bits   = words_per_line * word_bits;

    typedef logic [addr_bits-1:0]            addr_t;
    typedef logic [word_bits-1:0]            word_t;
    typedef logic [word_bits/8-1:0]          strb_t;
    typedef logic [index_bits-1:0]           index_t;
    typedef logic [tag_bits-1:0]             tag_t;
    typedef logic [line_bits-1:0]            line_t;

    // line address as seen by L2, tag above index
    typedef logic [tag_bits+index_bits-1:0]  line_addr_t;

endpackage
